// ==== all.f ====
+incdir+.
wb_pkg.sv
io_pkg.sv
uart_tx_sequencer.sv
bus_req_fifo.sv
wb_master.sv
io_regs.sv
iobus_top.sv
tb_clkgen.sv
tb_iobus.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
   verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_iobus -f all.f &&
   ./obj_dir/Vtb_iobus | tee /dev/stderr | grep -q "TEST OK" &&
   echo "simulation passed" ||
   { echo "simulation failed"; exit 1; }

// ==== tb_iobus.sv ====
// Testbench for the IO bus top driving host commands and checking serial frames and LED levels
`timescale 1ns/100ps
`default_nettype none
`include "iobus_cfg.svh"

module tb_iobus
   import io_pkg::*;
();

   localparam int CPB      = `IOBUS_CLKS_PER_BIT;
   localparam int FRAME_TO = 12 * CPB + 40;   // Cycles allowed for one whole frame
   localparam int IDLE_TO  = 2 * CPB + 20;

   logic       CLK_I;
   logic       rst;
   io_cmd_t    cmd;
   logic       cmd_stb;
   logic       busy;
   logic       rx;
   logic       tx;
   logic       led_red;
   logic       led_green;
   logic       led_blue;
   logic [7:0] frames[$];                     // Bytes decoded from tx

   tb_clkgen i_clkgen (.CLK_I(CLK_I), .rst(rst));

   iobus_top i_iobus_top (.*);

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp)
         else report_failure($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_idle();
      expect_val("tx", 32'(tx), 32'd1);
      expect_val("leds", 32'({led_blue, led_green, led_red}), 32'd0);
      expect_val("busy", 32'(busy), 32'd0);
   endtask

   // One-cycle strobe without back-pressure
   task automatic drive_cmd(input io_cmd_t c);
      @(posedge CLK_I);
      cmd     <= c;
      cmd_stb <= 1'b1;
      @(posedge CLK_I);
      cmd_stb <= 1'b0;
      @(negedge CLK_I);                       // Busy settled after the accepting edge
   endtask

   task automatic send_led(input led_rgb_t rgb, input logic blue_uart, input logic set_src);
      io_cmd_t c;
      c           = '0;
      c.kind      = CMD_LED;
      c.rgb       = rgb;
      c.blue_uart = blue_uart;
      c.set_src   = set_src;
      drive_cmd(c);
   endtask

   task automatic send_byte(input logic [7:0] data);
      io_cmd_t c;
      c      = '0;
      c.kind = CMD_TX_BYTE;
      c.data = data;
      drive_cmd(c);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < FRAME_TO) begin
         @(negedge CLK_I);
         n++;
      end
      assert (!busy) else report_failure("busy stayed high past the timeout");
   endtask

   task automatic wait_leds(input led_rgb_t exp);
      int n;
      n = 0;
      while ({led_blue, led_green, led_red} != exp && n < IDLE_TO) begin
         @(negedge CLK_I);
         n++;
      end
      expect_val("leds", 32'({led_blue, led_green, led_red}), 32'(exp));
   endtask

   task automatic expect_frame(input logic [7:0] exp);
      int n;
      n = 0;
      while (frames.size() == 0 && n < FRAME_TO) begin
         @(negedge CLK_I);
         n++;
      end
      assert (frames.size() != 0) else report_failure("no serial frame appeared on tx in time");
      expect_val("tx_byte", 32'(frames.pop_front()), 32'(exp));
   endtask

   // Blue must track random rx levels after the two sync flops
   task automatic check_mirror(input led_rgb_t rgb);
      logic [31:0] rnd;
      for (int i = 0; i < 16; i++) begin
         rnd = $urandom;
         @(posedge CLK_I);
         rx <= rnd[0];
         repeat (4) @(negedge CLK_I);
         expect_val("led_blue", 32'(led_blue), 32'(rnd[0]));
         expect_val("led_red_green", 32'({led_green, led_red}), 32'(rgb[1:0]));
      end
   endtask

   // Frame decoder sampling every bit over its full period
   initial begin : frame_monitor
      logic       prev;
      logic       first;
      logic [9:0] bits;
      prev = 1'b1;
      forever begin
         @(negedge CLK_I);
         if (!rst && prev && !tx) begin       // Start edge
            for (int b = 0; b < 10; b++) begin
               for (int c = 0; c < CPB; c++) begin
                  if (b != 0 || c != 0) @(negedge CLK_I);
                  if (c == 0) first = tx;
                  if (c == CPB / 2) bits[b] = tx;   // Bit middle
                  expect_val("tx", 32'(tx), 32'(first));
               end
            end
            expect_val("stop_bit", 32'(bits[9]), 32'd1);
            frames.push_back(bits[8:1]);
         end
         prev = tx;
      end
   end

   initial begin
      int          n;
      logic [31:0] rnd;
      logic [7:0]  first_byte;
      cmd     = '0;
      cmd_stb = 1'b0;
      rx      = 1'b1;                         // Line idle
      rnd     = $urandom(32'h471f);
      n = 0;
      do begin                                // Reset values while and after reset
         @(negedge CLK_I);
         check_idle();
         n++;
      end while (rst && n < 20);
      assert (!rst) else report_failure("reset never released");
      check_idle();
      send_led(3'b001, 1'b1, 1'b0);           // Source flag ignored without set_src
      wait_leds(3'b001);
      wait_idle();
      for (int i = 0; i < 40; i++) begin
         rnd = $urandom;
         send_byte(rnd[7:0]);
         expect_frame(rnd[7:0]);
         wait_idle();
      end
      rnd        = $urandom;
      first_byte = rnd[7:0];
      send_byte(first_byte);
      repeat (5) @(negedge CLK_I);
      expect_val("busy", 32'(busy), 32'd1);
      send_byte(~first_byte);                 // Must be dropped
      expect_frame(first_byte);
      wait_idle();
      for (int i = 0; i < FRAME_TO; i++) begin
         @(negedge CLK_I);
         expect_val("tx", 32'(tx), 32'd1);
      end
      expect_val("frame_count", 32'(frames.size()), 32'd0);
      send_led(3'b011, 1'b1, 1'b1);           // Blue follows rx
      wait_idle();
      check_mirror(3'b011);
      send_led(3'b100, 1'b0, 1'b1);           // Back to register bit
      wait_idle();
      @(posedge CLK_I);
      rx <= 1'b0;
      repeat (4) @(negedge CLK_I);
      expect_val("leds", 32'({led_blue, led_green, led_red}), 32'd4);
      send_led(3'b000, 1'b1, 1'b1);
      wait_idle();
      send_led(3'b111, 1'b0, 1'b0);           // New colour while the source is kept
      wait_idle();
      check_mirror(3'b111);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
// Testbench clock and reset source, 8 ns period, reset held for the first two cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
   output logic CLK_I,
   output logic rst
);

   initial begin
      CLK_I = 1'b0;
      forever #4 CLK_I = ~CLK_I;     // 125 MHz
   end

   initial begin
      rst = 1'b1;
      repeat (2) @(posedge CLK_I);
      rst <= 1'b0;                   // Released on the second edge
   end

endmodule

`default_nettype wire

// ==== iobus_top.sv ====
// IO bus top: command sequencer feeding a request FIFO, Wishbone master and IO registers
`timescale 1ns/100ps
`default_nettype none

module iobus_top
   import wb_pkg::*;
   import io_pkg::*;
(
   input  logic    CLK_I,
   input  logic    rst,
   input  io_cmd_t cmd,
   input  logic    cmd_stb,
   output logic    busy,
   input  logic    rx,
   output logic    tx,
   output logic    led_red,
   output logic    led_green,
   output logic    led_blue
);

   wb_req_t seq_req;      // Sequencer to FIFO
   logic    seq_push;
   wb_req_t fifo_head;    // FIFO to master
   logic    fifo_not_empty;
   logic    fifo_pop;
   logic    wb_cyc;       // Master to slave
   logic    wb_stb;
   logic    wb_we;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat;
   wb_sel_t wb_sel;
   logic    wb_ack;

   uart_tx_sequencer i_uart_tx_sequencer (
      .CLK_I   (CLK_I),
      .rst     (rst),
      .cmd     (cmd),
      .cmd_stb (cmd_stb),
      .req     (seq_req),
      .push    (seq_push),
      .busy    (busy)
   );

   bus_req_fifo i_bus_req_fifo (
      .CLK_I     (CLK_I),
      .rst       (rst),
      .push      (seq_push),
      .wr_req    (seq_req),
      .pop       (fifo_pop),
      .rd_req    (fifo_head),
      .not_empty (fifo_not_empty)
   );

   wb_master i_wb_master (
      .CLK_I     (CLK_I),
      .rst       (rst),
      .not_empty (fifo_not_empty),
      .head      (fifo_head),
      .pop       (fifo_pop),
      .cyc       (wb_cyc),
      .stb       (wb_stb),
      .we        (wb_we),
      .adr       (wb_adr),
      .dat       (wb_dat),
      .sel       (wb_sel),
      .ack       (wb_ack)
   );

   io_regs i_io_regs (
      .CLK_I     (CLK_I),
      .rst       (rst),
      .cyc       (wb_cyc),
      .stb       (wb_stb),
      .we        (wb_we),
      .adr       (wb_adr),
      .dat       (wb_dat),
      .sel       (wb_sel),
      .ack       (wb_ack),
      .rx        (rx),
      .tx        (tx),
      .led_red   (led_red),
      .led_green (led_green),
      .led_blue  (led_blue)
   );

endmodule

`default_nettype wire

// ==== io_regs.sv ====
// Wishbone IO slave: LED register, serial transmit pin, blue LED source and rx synchroniser
`timescale 1ns/100ps
`default_nettype none
`include "iobus_cfg.svh"

module io_regs
   import wb_pkg::*;
   import io_pkg::*;
(
   input  logic    CLK_I,
   input  logic    rst,
   input  logic    cyc,
   input  logic    stb,
   input  logic    we,
   input  wb_adr_t adr,
   input  wb_dat_t dat,
   input  wb_sel_t sel,
   output logic    ack,
   input  logic    rx,
   output logic    tx,
   output logic    led_red,
   output logic    led_green,
   output logic    led_blue
);

   led_rgb_t led_q;          // Written colour
   logic     blue_uart;      // Blue mirrors rx when set
   logic     rx_meta;        // First sync stage
   logic     rx_sync;        // Safe to use
   logic     wr_first;       // First stb cycle of a write
   logic     led_wr;
   logic     tx_wr;

   // Ack still low marks the first stb cycle, so each cycle writes once
   assign wr_first = cyc & stb & we & ~ack;
   assign led_wr   = wr_first & adr[`IOBUS_LED_ADR_BIT];
   assign tx_wr    = wr_first & adr[`IOBUS_TX_ADR_BIT] & sel[0];

   // One-shot ack the cycle after stb rises
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         ack <= 1'b0;
      end else begin
         ack <= cyc & stb & ~ack;
      end
   end

   // LED register and blue source
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         led_q     <= '0;            // All off
         blue_uart <= 1'b0;
      end else if (led_wr) begin
         if (sel[0]) begin
            led_q <= dat[2:0];
         end
         if (sel[3]) begin
            blue_uart <= dat[31];    // Lane 3 carries the source flag
         end
      end
   end

   // Transmit pin, idles as mark
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         tx <= 1'b1;
      end else if (tx_wr) begin
         tx <= dat[0];
      end
   end

   // Two flops against metastability
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
      end
   end

   assign led_red   = led_q[0];
   assign led_green = led_q[1];
   assign led_blue  = blue_uart ? rx_sync : led_q[2];   // Loopback view of rx

endmodule

`default_nettype wire

// ==== wb_master.sv ====
// Single Wishbone master, one classic write cycle per buffered request
`timescale 1ns/100ps
`default_nettype none

module wb_master
   import wb_pkg::*;
   import io_pkg::*;
(
   input  logic    CLK_I,
   input  logic    rst,
   input  logic    not_empty,
   input  wb_req_t head,
   output logic    pop,
   output logic    cyc,
   output logic    stb,
   output logic    we,
   output wb_adr_t adr,
   output wb_dat_t dat,
   output wb_sel_t sel,
   input  logic    ack
);

   mst_state_t state;
   logic       active;

   // Take the head as soon as the bus is free
   assign pop = (state == MST_IDLE) & not_empty;

   // All three strobes rise and fall together, writes only
   assign active = (state == MST_CYCLE);
   assign cyc    = active;
   assign stb    = active;
   assign we     = active;

   always_ff @(posedge CLK_I) begin
      if (rst) begin
         state <= MST_IDLE;
      end else begin
         case (state)
            MST_IDLE: begin
               if (not_empty) begin
                  state <= MST_CYCLE;   // Strobes up next cycle
               end
            end
            MST_CYCLE: begin
               if (ack) begin
                  state <= MST_IDLE;    // Leaves at least one idle cycle
               end
            end
            default: state <= MST_IDLE;
         endcase
      end
   end

   // Address, data and lanes held for the whole cycle
   always_ff @(posedge CLK_I) begin
      if (pop) begin
         adr <= head.adr;
         dat <= head.dat;
         sel <= head.sel;
      end
   end

endmodule

`default_nettype wire

// ==== bus_req_fifo.sv ====
// Small synchronous FIFO carrying bus write requests from sequencer to master
`timescale 1ns/100ps
`default_nettype none
`include "iobus_cfg.svh"

module bus_req_fifo
   import wb_pkg::*;
(
   input  logic    CLK_I,
   input  logic    rst,
   input  logic    push,
   input  wb_req_t wr_req,
   input  logic    pop,
   output wb_req_t rd_req,
   output logic    not_empty
);

   localparam int AW    = `IOBUS_FIFO_AW;
   localparam int DEPTH = 1 << AW;

   wb_req_t       mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;          // One bit wider to tell full from empty
   logic          full;
   logic          do_push;
   logic          do_pop;

   assign full      = (count == (AW+1)'(DEPTH));
   assign not_empty = (count != '0);
   assign do_push   = push & ~full;      // Lost when full
   assign do_pop    = pop & not_empty;

   assign rd_req = mem[rd_ptr];          // Head shown without delay

   // Storage
   always_ff @(posedge CLK_I) begin
      if (do_push) begin
         mem[wr_ptr] <= wr_req;
      end
   end

   // Pointers and fill level
   always_ff @(posedge CLK_I) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;     // Wraps at DEPTH
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // Simultaneous push and pop keep the level
         count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
      end
   end

endmodule

`default_nettype wire

// ==== uart_tx_sequencer.sv ====
// Turns host commands into bus write requests, paced one per serial bit period
`timescale 1ns/100ps
`default_nettype none
`include "iobus_cfg.svh"

module uart_tx_sequencer
   import wb_pkg::*;
   import io_pkg::*;
(
   input  logic    CLK_I,
   input  logic    rst,
   input  io_cmd_t cmd,
   input  logic    cmd_stb,
   output wb_req_t req,
   output logic    push,
   output logic    busy
);

   localparam int CNT_W = $clog2(`IOBUS_CLKS_PER_BIT);
   localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`IOBUS_CLKS_PER_BIT - 1);

   seq_state_t       state;
   logic [CNT_W-1:0] cnt;          // Cycles left in current bit period
   logic [3:0]       bit_idx;      // Frame bit last issued, 0 start .. 9 stop
   tx_byte_t         shreg;        // Remaining data bits, LSB next
   logic             accept;
   logic             step;

   // Write of one line level to the transmit register
   function automatic wb_req_t tx_req(input logic level);
      wb_req_t r;
      r = '0;
      r.adr[`IOBUS_TX_ADR_BIT] = 1'b1;
      r.dat[0] = level;
      r.sel = 4'b0001;
      return r;
   endfunction

   // LED register write, lane 3 only if blue source is to change
   function automatic wb_req_t led_req(input io_cmd_t c);
      wb_req_t r;
      r = '0;
      r.adr[`IOBUS_LED_ADR_BIT] = 1'b1;
      r.dat[2:0] = c.rgb;
      r.dat[31] = c.blue_uart;
      r.sel = {c.set_src, 3'b001};
      return r;
   endfunction

   assign accept = cmd_stb & (state == SEQ_IDLE);   // Busy drops the command
   assign step   = (state == SEQ_SEND) && (cnt == '0) && (bit_idx != 4'd9);
   assign busy   = (state != SEQ_IDLE);

   always_ff @(posedge CLK_I) begin
      if (rst) begin
         state   <= SEQ_IDLE;
         push    <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else begin
         push <= 1'b0;                              // One-cycle strobe
         case (state)
            SEQ_IDLE: begin
               if (accept) begin
                  state   <= SEQ_SEND;
                  push    <= 1'b1;                  // First request right away
                  cnt     <= CNT_LOAD;
                  // LED write is a frame of one, jump straight to last index
                  bit_idx <= (cmd.kind == CMD_LED) ? 4'd9 : 4'd0;
               end
            end
            SEQ_SEND: begin
               if (cnt != '0) begin
                  cnt <= cnt - 1'b1;
               end else if (bit_idx == 4'd9) begin
                  state <= SEQ_IDLE;                // Last period elapsed
               end else begin
                  push    <= 1'b1;
                  cnt     <= CNT_LOAD;
                  bit_idx <= bit_idx + 4'd1;
               end
            end
            default: state <= SEQ_IDLE;
         endcase
      end
   end

   // Request word and byte copy
   always_ff @(posedge CLK_I) begin
      if (accept) begin
         shreg <= cmd.data;
         req   <= (cmd.kind == CMD_LED) ? led_req(cmd) : tx_req(1'b0);  // Start bit is 0
      end else if (step) begin
         req   <= tx_req((bit_idx == 4'd8) ? 1'b1 : shreg[0]);          // Stop bit after bit 7
         shreg <= shreg >> 1;
      end
   end

endmodule

`default_nettype wire

// ==== io_pkg.sv ====
// IO-side types: LED colour, host commands and the state encodings of the two FSMs
`default_nettype none

package io_pkg;

   // Red in bit 0, green in bit 1, blue in bit 2, same order as LED register data
   typedef logic [2:0] led_rgb_t;

   typedef logic [7:0] tx_byte_t;   // Serial payload

   typedef enum logic {
      CMD_TX_BYTE,                  // Send one byte on the serial pin
      CMD_LED                       // Write the LED register
   } io_cmd_kind_t;

   // Host command, valid with cmd_stb
   typedef struct packed {
      io_cmd_kind_t kind;
      tx_byte_t     data;           // Byte for CMD_TX_BYTE
      led_rgb_t     rgb;            // Colour for CMD_LED
      logic         blue_uart;      // Blue follows rx when set
      logic         set_src;        // Update blue source only when set
   } io_cmd_t;

   // Command sequencer
   typedef enum logic {SEQ_IDLE, SEQ_SEND} seq_state_t;

   // Bus master
   typedef enum logic {MST_IDLE, MST_CYCLE} mst_state_t;

endpackage

`default_nettype wire

// ==== wb_pkg.sv ====
// Bus-side types shared by the request producer, the buffer, the master and the IO slave
`default_nettype none

package wb_pkg;

   // Byte address as seen on the bus
   typedef logic [31:0] wb_adr_t;

   // Write data word
   typedef logic [31:0] wb_dat_t;

   // One select bit per byte lane
   typedef logic [3:0] wb_sel_t;

   // A single queued write
   typedef struct packed {
      wb_adr_t adr;                 // Target register
      wb_dat_t dat;                 // Value to write
      wb_sel_t sel;                 // Lanes to update
   } wb_req_t;

endpackage

`default_nettype wire

// ==== iobus_cfg.svh ====
// Build-time constants of the IO bus: serial bit timing, request buffer size, register decode
`ifndef IOBUS_CFG_SVH
`define IOBUS_CFG_SVH

// Clock cycles per serial bit, must stay at 8 or more
`define IOBUS_CLKS_PER_BIT 16

// Request buffer holds 2**AW entries
`define IOBUS_FIFO_AW 2

// Address bit that selects the LED register
`define IOBUS_LED_ADR_BIT 2

// Address bit that selects the serial transmit register
`define IOBUS_TX_ADR_BIT 3

`endif
